//--- sim/uart_golden.txt
# Column 1: T transmit, R receive, C clear-to-send level, G one-cycle rxd glitch
# Column 2: hex byte for T and R, level 0 or 1 for C, unused for G
T 55
T A3
T 00
T FF
T 01
T 80
C 1
T 5A
C 0
T C3
R 55
R A5
R 00
R FF
R 3C
R 81
R 7E
G 0
R 96
R 01
R 80
G 0
R E7
C 1
T 24
C 0
R 42
T 99

//--- src.f
+incdir+sim
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_core.sv
sim/tb_uart_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the serial port testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_uart_core -o tb_uart_core

output="$(./obj_dir/tb_uart_core)"
echo "$output"

if echo "$output" | grep -q "^All checks passed$"; then
    exit 0
else
    exit 1
fi

//--- sim/uart_tb_checks.svh
// Compare tasks and result counters for the serial port testbench
// Included inside tb_uart_core after the package import
// A wrong value prints one line starting with Error and the time
// Other failures print a plain sentence and count as errors too

`ifndef UART_TB_CHECKS_SVH
`define UART_TB_CHECKS_SVH

// Result counters
int err_count   = 0;
int check_count = 0;
int test_count  = 0;
int fail_count  = 0;

// Byte results, both directions
task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("Error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
endtask

// Line levels and single conditions
task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// Timeouts and file problems
task automatic report_failure(input string msg);
    err_count++;
    $display("%s", msg);
endtask

// One line per finished test
task automatic end_test(input string desc, input int errs_before);
    test_count++;
    if (err_count == errs_before)
        $display("Test %0d (%s): ok", test_count, desc);
    else
    begin
        fail_count++;
        $display("Test %0d (%s): FAILED with %0d errors", test_count, desc,
                 err_count - errs_before);
    end
endtask

`endif

//--- sim/tb_uart_core.sv
// Testbench for the serial port top level
// Operations and expected bytes come from sim/uart_golden.txt,
// opened relative to the project root
// Both serial lines run at CLKS_PER_BIT clocks per bit
// Receive gaps are random, every third frame follows back to back

`timescale 1ns/100ps

module tb_uart_core
    import uart_pkg::*;
();

    localparam int BIT_CLKS   = int'(CLKS_PER_BIT);
    localparam int HALF_BIT   = BIT_CLKS / 2;
    // Ideal 12 bit word at 2.9 MBd from 50 MHz in whole clocks
    localparam int WORD_CLKS  = 207;
    // Second stop period takes what is left of the word after 11 bits
    localparam int ADJ_CLKS   = WORD_CLKS - 11 * BIT_CLKS;
    localparam int WAIT_LIMIT = 20 * WORD_CLKS;
    localparam int RAND_SEED  = 76928;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_tx_start;
    uart_byte_t i_tx_data;
    logic       o_tx_busy;
    logic       o_tx_done;
    logic       o_txd;
    logic       i_cts_n;
    logic       i_rxd;
    logic       o_rts_n;
    uart_byte_t o_rx_data;
    logic       o_rx_valid;

    // Byte held back by clear-to-send
    logic       tx_pending;
    uart_byte_t pending_byte;
    int         rx_count;

    `include "uart_tb_checks.svh"

    uart_core i_uart_core (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .o_tx_busy  (o_tx_busy),
        .o_tx_done  (o_tx_done),
        .o_txd      (o_txd),
        .i_cts_n    (i_cts_n),
        .i_rxd      (i_rxd),
        .o_rts_n    (o_rts_n),
        .o_rx_data  (o_rx_data),
        .o_rx_valid (o_rx_valid)
    );

    // 20 ns clock
    always #10 i_clk = ~i_clk;

    // ==================================================
    // Transmit side
    // ==================================================

    // One-cycle strobe with the byte
    task automatic strobe_tx(input uart_byte_t b);
        @(posedge i_clk);
        i_tx_start <= 1'b1;
        i_tx_data  <= b;
        @(posedge i_clk);
        i_tx_start <= 1'b0;
    endtask

    // Watch o_txd from the start edge until busy falls
    task automatic check_tx_frame(input uart_byte_t exp);
        int         cyc;
        int         idx;
        int         done_cnt;
        int         done_at;
        int         frame_len;
        logic       seen_edge;
        uart_byte_t got;
        seen_edge = 1'b0;
        cyc       = 0;
        while (!seen_edge && cyc < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            cyc++;
            if (o_txd === 1'b0)
                seen_edge = 1'b1;
        end
        if (!seen_edge)
            report_failure("Timeout: o_txd never fell for a start bit");
        else
        begin
            // Start bit, 8 data bits, 3 stop periods
            frame_len = 9 * BIT_CLKS + BIT_CLKS + ADJ_CLKS + BIT_CLKS;
            got       = '0;
            done_cnt  = 0;
            done_at   = 0;
            cyc       = 0;
            while (o_tx_busy && cyc < WAIT_LIMIT)
            begin
                @(negedge i_clk);
                cyc++;
                // Mid-bit sample points, index 1 is data bit 0
                if (cyc > HALF_BIT && ((cyc - HALF_BIT) % BIT_CLKS) == 0)
                begin
                    idx = (cyc - HALF_BIT) / BIT_CLKS;
                    if (idx <= 8)
                        got = {o_txd, got[7:1]};
                    else if (idx <= 11 && done_cnt == 0)
                        check_bit("o_txd in stop period", o_txd, 1'b1);
                end
                if (o_tx_done)
                begin
                    done_cnt++;
                    if (done_cnt == 1)
                        done_at = cyc;
                end
            end
            if (o_tx_busy)
                report_failure("Timeout: o_tx_busy never fell after a frame");
            check_byte("transmitted byte", got, exp);
            check_bit("single o_tx_done pulse", (done_cnt == 1), 1'b1);
            check_bit($sformatf("frame length %0d clocks in range", done_at),
                      (done_at >= frame_len && done_at <= frame_len + 3), 1'b1);
        end
    endtask

    // Line and busy must hold while clear-to-send is high
    task automatic check_cts_hold();
        int cyc;
        int txd_low;
        int busy_low;
        txd_low  = 0;
        busy_low = 0;
        for (cyc = 0; cyc < 10 * WORD_CLKS; cyc++)
        begin
            @(negedge i_clk);
            if (o_txd !== 1'b1)
                txd_low++;
            if (o_tx_busy !== 1'b1)
                busy_low++;
        end
        check_bit("o_txd held high while blocked", (txd_low == 0), 1'b1);
        check_bit("o_tx_busy held while blocked", (busy_low == 0), 1'b1);
    endtask

    // ==================================================
    // Receive side
    // ==================================================

    // Idle gap, then start, data LSB first and one stop bit
    task automatic send_rx_frame(input uart_byte_t b, input int gap);
        int         bit_idx;
        int         c;
        int         valid_cnt;
        logic       level;
        uart_byte_t shifter;
        uart_byte_t got;
        valid_cnt = 0;
        shifter   = b;
        got       = '0;
        for (c = 0; c < gap; c++)
        begin
            @(posedge i_clk);
            i_rxd <= 1'b1;
        end
        for (bit_idx = 0; bit_idx < 10; bit_idx++)
        begin
            if (bit_idx == 0)
                level = 1'b0;
            else if (bit_idx <= 8)
            begin
                level   = shifter[0];
                shifter = shifter >> 1;
            end
            else
                level = 1'b1;
            for (c = 0; c < BIT_CLKS; c++)
            begin
                @(posedge i_clk);
                i_rxd <= level;
                @(negedge i_clk);
                if (o_rx_valid)
                begin
                    valid_cnt++;
                    got = o_rx_data;
                end
            end
        end
        // Late strobe, only reached when the receiver is slow
        c = 0;
        while (valid_cnt == 0 && c < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            c++;
            if (o_rx_valid)
            begin
                valid_cnt++;
                got = o_rx_data;
            end
        end
        if (valid_cnt == 0)
            report_failure("Timeout: o_rx_valid never pulsed for a frame");
        else
        begin
            check_bit("single o_rx_valid pulse", (valid_cnt == 1), 1'b1);
            check_byte("received byte", got, b);
        end
    endtask

    // One-cycle low pulse must not start a frame
    task automatic send_glitch();
        int cyc;
        int valid_cnt;
        valid_cnt = 0;
        @(posedge i_clk);
        i_rxd <= 1'b0;
        @(posedge i_clk);
        i_rxd <= 1'b1;
        for (cyc = 0; cyc < 2 * WORD_CLKS; cyc++)
        begin
            @(negedge i_clk);
            if (o_rx_valid)
                valid_cnt++;
        end
        check_bit("no o_rx_valid after glitch", (valid_cnt == 0), 1'b1);
    endtask

    // ==================================================
    // Reset and golden file
    // ==================================================

    task automatic check_reset();
        int cyc;
        @(posedge i_clk);
        @(posedge i_clk);
        @(negedge i_clk);
        check_bit("o_txd in reset", o_txd, 1'b1);
        check_bit("o_tx_busy in reset", o_tx_busy, 1'b0);
        check_bit("o_tx_done in reset", o_tx_done, 1'b0);
        check_bit("o_rx_valid in reset", o_rx_valid, 1'b0);
        check_bit("o_rts_n in reset", o_rts_n, 1'b1);
        // Third reset edge, released after it
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        cyc = 0;
        while (o_rts_n !== 1'b0 && cyc < 5)
        begin
            @(negedge i_clk);
            cyc++;
        end
        check_bit("o_rts_n after reset release", o_rts_n, 1'b0);
    endtask

    // Runs one operation per line, '#' lines are comments
    task automatic run_golden();
        int         fd;
        int         n;
        int         val;
        int         errs_before;
        int         gap;
        string      line;
        string      desc;
        logic [7:0] op;
        fd = $fopen("sim/uart_golden.txt", "r");
        if (fd == 0)
            report_failure("Could not open the golden file sim/uart_golden.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                op = line[0];
                if (line.len() >= 3 && op != "#")
                begin
                    errs_before = err_count;
                    n    = $sscanf(line.substr(2, line.len() - 1), "%h", val);
                    desc = $sformatf("%c %02h", op, val[7:0]);
                    if (n != 1)
                        report_failure("Golden file line has no readable value");
                    else if (op == "T")
                    begin
                        strobe_tx(val[7:0]);
                        if (i_cts_n)
                        begin
                            check_cts_hold();
                            tx_pending   = 1'b1;
                            pending_byte = val[7:0];
                        end
                        else
                            check_tx_frame(val[7:0]);
                    end
                    else if (op == "R")
                    begin
                        // Every third frame back to back
                        gap = (rx_count % 3 == 2) ? 0 : int'($urandom % 41);
                        rx_count++;
                        send_rx_frame(val[7:0], gap);
                    end
                    else if (op == "C")
                    begin
                        @(posedge i_clk);
                        i_cts_n <= val[0];
                        if (!val[0] && tx_pending)
                        begin
                            check_tx_frame(pending_byte);
                            tx_pending = 1'b0;
                        end
                    end
                    else if (op == "G")
                        send_glitch();
                    else
                        report_failure("Golden file line has an unknown operation");
                    end_test(desc, errs_before);
                end
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        int errs_before;
        void'($urandom(RAND_SEED));
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_tx_start   = 1'b0;
        i_tx_data    = '0;
        i_cts_n      = 1'b0;
        i_rxd        = 1'b1;
        tx_pending   = 1'b0;
        pending_byte = '0;
        rx_count     = 0;
        errs_before  = err_count;
        check_reset();
        end_test("reset state", errs_before);
        run_golden();
        if (tx_pending)
            report_failure("A byte was still held by clear-to-send at the end");
        if (test_count < 2)
            report_failure("No operations were read from the golden file");
        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_count, fail_count, check_count, err_count);
        if (err_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- rtl/uart_core.sv
// Top level of the serial port
// Transmit and receive paths are fully independent
// Baud rate is fixed by the constants in the package
// Handshake lines are active low, as on the connector

`timescale 1ns/100ps

module uart_core
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Transmit side
    input  logic       i_tx_start,
    input  uart_byte_t i_tx_data,
    output logic       o_tx_busy,
    output logic       o_tx_done,
    output logic       o_txd,
    input  logic       i_cts_n,

    // Receive side
    input  logic       i_rxd,
    output logic       o_rts_n,
    output uart_byte_t o_rx_data,
    output logic       o_rx_valid
);

    // Transmitter, gated by clear-to-send
    uart_tx u_uart_tx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .i_cts_n    (i_cts_n),
        .o_txd      (o_txd),
        .o_tx_busy  (o_tx_busy),
        .o_tx_done  (o_tx_done)
    );

    // Receiver, drives request-to-send
    uart_rx u_uart_rx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rxd      (i_rxd),
        .o_rts_n    (o_rts_n),
        .o_rx_data  (o_rx_data),
        .o_rx_valid (o_rx_valid)
    );

endmodule

//--- rtl/uart_rx.sv
// Serial receiver, 8 data bits LSB first
// Start needs two high then two low filtered samples, so
// single-cycle glitches are ignored
// The stop bit level is not checked
// o_rx_data is valid from the o_rx_valid pulse until the next first sample
// No back-pressure; an unread byte is overwritten

`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_rxd,
    output logic       o_rts_n,
    output uart_byte_t o_rx_data,
    output logic       o_rx_valid
);

    logic [RXD_FILT_LEN-1:0]   rxd_filt;
    logic                      rx_start;
    bit_cnt_t                  rx_bit_cnt;
    logic                      restart_cnt;
    logic                      restart_next;
    logic                      half_hit;
    logic                      bit_hit;
    logic                      rx_en;
    rx_state_t                 rx_state;

    // Ready to receive once the FSM has left reset
    assign o_rts_n = ~rx_en;

    // ==================================================
    // Start filter
    // ==================================================

    // Newest sample enters at bit 0
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            rxd_filt <= '1;
        else
            rxd_filt <= {rxd_filt[RXD_FILT_LEN-2:0], i_rxd};
    end

    // Clean 1 to 0 transition, middle sample ignored
    assign rx_start = (rxd_filt[RXD_FILT_LEN-1:RXD_FILT_LEN-2] == 2'b11) &&
                      (rxd_filt[1:0] == 2'b00);

    // ==================================================
    // Restartable bit counter
    // ==================================================

    assign half_hit = (rx_bit_cnt == RX_HALF_COUNT);
    assign bit_hit  = (rx_bit_cnt == RX_BIT_COUNT);

    // Restart request for the next cycle
    always_comb
    begin
        case (rx_state)
            RX_IDLE:       restart_next = 1'b1;
            RX_START:      restart_next = rx_start;
            // Hold restart while the counter clears
            RX_START_MID1: restart_next = 1'b1;
            RX_START_MID:  restart_next = half_hit;
            default:       restart_next = bit_hit;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            restart_cnt <= 1'b1;
            rx_bit_cnt  <= '0;
        end
        else
        begin
            restart_cnt <= restart_next;
            if (restart_cnt)
                rx_bit_cnt <= '0;
            else
                rx_bit_cnt <= rx_bit_cnt + bit_cnt_t'(1);
        end
    end

    // ==================================================
    // Receive state machine
    // ==================================================

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            rx_state   <= RX_IDLE;
            rx_en      <= 1'b0;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            o_rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE:
                begin
                    rx_state <= RX_START;
                    rx_en    <= 1'b1;
                end
                RX_START:
                    if (rx_start)
                        rx_state <= RX_START_MID1;
                RX_START_MID1:
                    rx_state <= RX_START_MID;
                // Counted to the middle of the start bit
                RX_START_MID:
                    if (half_hit)
                        rx_state <= RX_DATA0;
                RX_DATA0:
                    if (bit_hit)
                        rx_state <= RX_DATA1;
                RX_DATA1:
                    if (bit_hit)
                        rx_state <= RX_DATA2;
                RX_DATA2:
                    if (bit_hit)
                        rx_state <= RX_DATA3;
                RX_DATA3:
                    if (bit_hit)
                        rx_state <= RX_DATA4;
                RX_DATA4:
                    if (bit_hit)
                        rx_state <= RX_DATA5;
                RX_DATA5:
                    if (bit_hit)
                        rx_state <= RX_DATA6;
                RX_DATA6:
                    if (bit_hit)
                        rx_state <= RX_DATA7;
                RX_DATA7:
                    if (bit_hit)
                        rx_state <= RX_STOP;
                // Mid stop bit, byte is complete
                RX_STOP:
                    if (bit_hit)
                    begin
                        rx_state   <= RX_IDLE;
                        o_rx_valid <= 1'b1;
                    end
                default:
                    rx_state <= RX_IDLE;
            endcase
        end
    end

    // Data sampling at mid-bit, one bit per data state
    always_ff @(posedge i_clk)
    begin
        if (bit_hit)
        begin
            case (rx_state)
                RX_DATA0: o_rx_data[0] <= i_rxd;
                RX_DATA1: o_rx_data[1] <= i_rxd;
                RX_DATA2: o_rx_data[2] <= i_rxd;
                RX_DATA3: o_rx_data[3] <= i_rxd;
                RX_DATA4: o_rx_data[4] <= i_rxd;
                RX_DATA5: o_rx_data[5] <= i_rxd;
                RX_DATA6: o_rx_data[6] <= i_rxd;
                RX_DATA7: o_rx_data[7] <= i_rxd;
                default:  o_rx_data <= o_rx_data;
            endcase
        end
    end

    // ==================================================
    // Assertions
    // ==================================================

    // One strobe per received frame
    a_valid_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rx_valid |=> !o_rx_valid)
        else $error("uart_rx: o_rx_valid high on two consecutive cycles");

endmodule

//--- rtl/uart_tx.sv
// Serial transmitter, one byte at a time
// i_tx_start must not be pulsed while o_tx_busy is high
// Waits for clear-to-send low on three synchronized samples
// Frame ends with three high stop periods, the middle one stretched
// o_tx_busy falls the cycle after the o_tx_done pulse

`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_tx_start,
    input  uart_byte_t i_tx_data,
    input  logic       i_cts_n,
    output logic       o_txd,
    output logic       o_tx_busy,
    output logic       o_tx_done
);

    uart_byte_t                tx_byte;
    logic [CTS_SYNC_LEN-1:0]   cts_sync;
    logic                      cts_clear;
    bit_cnt_t                  tx_bit_cnt;
    bit_cnt_t                  pulse_limit;
    logic                      tx_bit_pulse;
    tx_state_t                 tx_state;

    // ==================================================
    // Holding register and busy flag
    // ==================================================

    // Byte is held for the whole frame
    always_ff @(posedge i_clk)
    begin
        if (i_tx_start)
            tx_byte <= i_tx_data;
    end

    // Busy doubles as the pending flag for the idle state
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_tx_busy <= 1'b0;
        else if (i_tx_start)
            o_tx_busy <= 1'b1;
        else if (o_tx_done)
            o_tx_busy <= 1'b0;
    end

    // Clear-to-send synchronizer, newest sample in bit 0
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            cts_sync <= '1;
        else
            cts_sync <= {cts_sync[CTS_SYNC_LEN-2:0], i_cts_n};
    end

    // Three oldest samples low
    assign cts_clear = (cts_sync[CTS_SYNC_LEN-1:CTS_SYNC_LEN-3] == 3'b000);

    // ==================================================
    // Bit pulse generator
    // ==================================================

    // Free running; shorter or longer period while in STOP2
    assign pulse_limit = (tx_state == TX_STOP2) ? TX_ADJUST_COUNT - bit_cnt_t'(1)
                                                : CLKS_PER_BIT - bit_cnt_t'(1);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            tx_bit_cnt   <= '0;
            tx_bit_pulse <= 1'b0;
        end
        else if (tx_bit_cnt == pulse_limit)
        begin
            tx_bit_cnt   <= '0;
            tx_bit_pulse <= 1'b1;
        end
        else
        begin
            tx_bit_cnt   <= tx_bit_cnt + bit_cnt_t'(1);
            tx_bit_pulse <= 1'b0;
        end
    end

    // ==================================================
    // Transmit state machine
    // ==================================================

    // Line level is updated together with the state, so it
    // always matches the bit the state stands for
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            tx_state  <= TX_IDLE;
            o_txd     <= 1'b1;
            o_tx_done <= 1'b0;
        end
        else
        begin
            o_tx_done <= 1'b0;
            if (tx_bit_pulse)
            begin
                case (tx_state)
                    TX_IDLE:
                    begin
                        // Falling edge of the start bit
                        if (o_tx_busy && cts_clear)
                        begin
                            tx_state <= TX_START;
                            o_txd    <= 1'b0;
                        end
                    end
                    TX_START:
                    begin
                        tx_state <= TX_DATA0;
                        o_txd    <= tx_byte[0];
                    end
                    TX_DATA0:
                    begin
                        tx_state <= TX_DATA1;
                        o_txd    <= tx_byte[1];
                    end
                    TX_DATA1:
                    begin
                        tx_state <= TX_DATA2;
                        o_txd    <= tx_byte[2];
                    end
                    TX_DATA2:
                    begin
                        tx_state <= TX_DATA3;
                        o_txd    <= tx_byte[3];
                    end
                    TX_DATA3:
                    begin
                        tx_state <= TX_DATA4;
                        o_txd    <= tx_byte[4];
                    end
                    TX_DATA4:
                    begin
                        tx_state <= TX_DATA5;
                        o_txd    <= tx_byte[5];
                    end
                    TX_DATA5:
                    begin
                        tx_state <= TX_DATA6;
                        o_txd    <= tx_byte[6];
                    end
                    TX_DATA6:
                    begin
                        tx_state <= TX_DATA7;
                        o_txd    <= tx_byte[7];
                    end
                    TX_DATA7:
                    begin
                        tx_state <= TX_STOP1;
                        o_txd    <= 1'b1;
                    end
                    // Line stays high through all stop periods
                    TX_STOP1: tx_state <= TX_STOP2;
                    TX_STOP2: tx_state <= TX_STOP3;
                    TX_STOP3:
                    begin
                        tx_state  <= TX_IDLE;
                        o_tx_done <= 1'b1;
                    end
                    default:
                    begin
                        tx_state <= TX_IDLE;
                        o_txd    <= 1'b1;
                    end
                endcase
            end
        end
    end

    // ==================================================
    // Assertions
    // ==================================================

    // Caller waits for busy to fall before the next strobe
    a_no_start_while_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tx_start |-> !o_tx_busy)
        else $error("uart_tx: i_tx_start while busy");

    // Line is at stop level whenever no start or data bit is on it
    a_txd_high_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (tx_state inside {TX_IDLE, TX_STOP1, TX_STOP2, TX_STOP3}) |-> o_txd)
        else $error("uart_tx: o_txd low outside start and data bits");

endmodule

//--- rtl/uart_pkg.sv
// Shared types and baud timing for the fixed-rate serial port
// Frame is 1 start bit, 8 data bits LSB first, no parity
// Baud rate is fixed at build time and derived from the system clock
// Rounding error is absorbed by stretching the middle stop bit
// Counters are 10 bits wide, so CLKS_PER_WORD must stay below 1024

package uart_pkg;

    // ==================================================
    // Types
    // ==================================================

    // One data byte of a frame
    typedef logic [7:0] uart_byte_t;

    // Bit-period counter value
    typedef logic [9:0] bit_cnt_t;

    // Transmit states, one per bit time on the line
    typedef enum logic [3:0] {
        TX_IDLE,
        TX_START,
        TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
        TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7,
        TX_STOP1,
        TX_STOP2,
        TX_STOP3
    } tx_state_t;

    // Receive states
    // START_MID1 gives the restarted counter one cycle to clear
    typedef enum logic [3:0] {
        RX_IDLE,
        RX_START,
        RX_START_MID1,
        RX_START_MID,
        RX_DATA0, RX_DATA1, RX_DATA2, RX_DATA3,
        RX_DATA4, RX_DATA5, RX_DATA6, RX_DATA7,
        RX_STOP
    } rx_state_t;

    // ==================================================
    // Baud timing
    // ==================================================

    localparam int CLK_FREQ_HZ = 50_000_000;
    localparam int UART_BAUD   = 2_900_000;

    // Rounded to the nearest whole clock
    localparam bit_cnt_t CLKS_PER_BIT  = bit_cnt_t'((CLK_FREQ_HZ + UART_BAUD / 2) / UART_BAUD);
    // A word is 12 bit times; 12 * 50 MHz still fits a 32 bit int
    localparam bit_cnt_t CLKS_PER_WORD =
        bit_cnt_t'((CLK_FREQ_HZ * 12 + UART_BAUD / 2) / UART_BAUD);

    // Middle stop bit length, so the whole frame matches the ideal word
    localparam bit_cnt_t TX_ADJUST_COUNT = CLKS_PER_WORD - bit_cnt_t'(11) * CLKS_PER_BIT;

    // Registered restart costs two cycles per bit
    localparam bit_cnt_t RX_BIT_COUNT  = CLKS_PER_BIT - bit_cnt_t'(2);
    // Start edge to mid start bit, less filter and restart latency
    localparam bit_cnt_t RX_HALF_COUNT = CLKS_PER_BIT / bit_cnt_t'(2) - bit_cnt_t'(4);

    // Shift register lengths
    localparam int CTS_SYNC_LEN = 4;
    localparam int RXD_FILT_LEN = 5;

endpackage
